//--- logic/rv_isa_pkg.sv
package rv_isa_pkg;

  localparam int XLEN = 32;
  localparam int REG_ADDR_W = 5;

  // major opcodes, bits [6:0] of every instruction
  localparam logic [6:0] OP_LOAD = 7'b000_0011;
  localparam logic [6:0] OP_STORE = 7'b010_0011;
  localparam logic [6:0] OP_BRANCH = 7'b110_0011;
  localparam logic [6:0] OP_JALR = 7'b110_0111;
  localparam logic [6:0] OP_JAL = 7'b110_1111;
  localparam logic [6:0] OP_MISC_MEM = 7'b000_1111;
  localparam logic [6:0] OP_OP_IMM = 7'b001_0011;
  localparam logic [6:0] OP_OP = 7'b011_0011;
  localparam logic [6:0] OP_SYSTEM = 7'b111_0011;
  localparam logic [6:0] OP_AUIPC = 7'b001_0111;
  localparam logic [6:0] OP_LUI = 7'b011_0111;

  // selects SUB over ADD and SRA over SRL
  localparam logic [6:0] F7_ALT = 7'b010_0000;

  // one instruction word seen through each base format
  typedef union packed {
    struct packed {
      logic [6:0] funct7;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } r;
    struct packed {
      logic [11:0] imm;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] rd;
      logic [6:0] opcode;
    } i;
    struct packed {
      logic [6:0] imm_hi;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [4:0] imm_lo;
      logic [6:0] opcode;
    } s;
    struct packed {
      logic imm_12;
      logic [5:0] imm_10_5;
      logic [4:0] rs2;
      logic [4:0] rs1;
      logic [2:0] funct3;
      logic [3:0] imm_4_1;
      logic imm_11;
      logic [6:0] opcode;
    } b;
    struct packed {
      logic [19:0] imm;
      logic [4:0] rd;
      logic [6:0] opcode;
    } u;
    struct packed {
      logic imm_20;
      logic [9:0] imm_10_1;
      logic imm_11;
      logic [7:0] imm_19_12;
      logic [4:0] rd;
      logic [6:0] opcode;
    } j;
  } insn_t;

endpackage

//--- logic/core_ctrl_pkg.sv
package core_ctrl_pkg;

  localparam int ALU_OP_W = 4;
  localparam logic [ALU_OP_W-1:0] ALU_ADD = 4'd0;
  localparam logic [ALU_OP_W-1:0] ALU_SUB = 4'd1;
  localparam logic [ALU_OP_W-1:0] ALU_SLL = 4'd2;
  localparam logic [ALU_OP_W-1:0] ALU_SLT = 4'd3;
  localparam logic [ALU_OP_W-1:0] ALU_SLTU = 4'd4;
  localparam logic [ALU_OP_W-1:0] ALU_XOR = 4'd5;
  localparam logic [ALU_OP_W-1:0] ALU_SRL = 4'd6;
  localparam logic [ALU_OP_W-1:0] ALU_SRA = 4'd7;
  localparam logic [ALU_OP_W-1:0] ALU_OR = 4'd8;
  localparam logic [ALU_OP_W-1:0] ALU_AND = 4'd9;

  localparam int IMM_SEL_W = 3;
  localparam logic [IMM_SEL_W-1:0] IMM_I = 3'd0;
  localparam logic [IMM_SEL_W-1:0] IMM_S = 3'd1;
  localparam logic [IMM_SEL_W-1:0] IMM_B = 3'd2;
  localparam logic [IMM_SEL_W-1:0] IMM_U = 3'd3;
  localparam logic [IMM_SEL_W-1:0] IMM_J = 3'd4;

  localparam int WB_SEL_W = 2;
  localparam logic [WB_SEL_W-1:0] WB_ALU = 2'd0;
  localparam logic [WB_SEL_W-1:0] WB_LOAD = 2'd1;
  localparam logic [WB_SEL_W-1:0] WB_PC_PLUS4 = 2'd2;
  localparam logic [WB_SEL_W-1:0] WB_IMM = 2'd3;

  localparam int PC_SEL_W = 2;
  localparam logic [PC_SEL_W-1:0] PC_SEQ = 2'd0;
  localparam logic [PC_SEL_W-1:0] PC_BRANCH = 2'd1;
  localparam logic [PC_SEL_W-1:0] PC_JAL = 2'd2;
  localparam logic [PC_SEL_W-1:0] PC_JALR = 2'd3;

  // same encoding as funct3[1:0] of loads and stores
  localparam int MEM_SIZE_W = 2;
  localparam logic [MEM_SIZE_W-1:0] MEM_BYTE = 2'd0;
  localparam logic [MEM_SIZE_W-1:0] MEM_HALF = 2'd1;
  localparam logic [MEM_SIZE_W-1:0] MEM_WORD = 2'd2;

endpackage

//--- logic/core_decoder.sv
`timescale 1ns/1ps

module core_decoder (
  input  rv_isa_pkg::insn_t                       insn,
  output logic                                    reg_we,
  output logic [core_ctrl_pkg::ALU_OP_W-1:0]      alu_op,
  output logic                                    alu_src_imm,
  output logic                                    alu_src_pc,
  output logic [core_ctrl_pkg::IMM_SEL_W-1:0]     imm_sel,
  output logic [core_ctrl_pkg::WB_SEL_W-1:0]      wb_sel,
  output logic [core_ctrl_pkg::PC_SEL_W-1:0]      pc_sel,
  output logic                                    is_load,
  output logic                                    is_store,
  output logic [core_ctrl_pkg::MEM_SIZE_W-1:0]    mem_size,
  output logic                                    load_unsigned,
  output logic [2:0]                              branch_funct,
  output logic                                    halt
);

  logic [6:0] opcode;
  logic [2:0] funct3;
  logic [6:0] funct7;
  logic [core_ctrl_pkg::ALU_OP_W-1:0] alu_code;
  logic imm_ok;
  logic op_ok;
  logic load_ok;
  logic is_ecall;

  assign opcode = insn.r.opcode;
  assign funct3 = insn.r.funct3;
  assign funct7 = insn.r.funct7;

  // funct7 only picks the alternate form for register-register add and for shifts right
  always_comb begin
    case (funct3)
      3'b000: alu_code = (opcode == rv_isa_pkg::OP_OP && funct7 == rv_isa_pkg::F7_ALT) ?
                         core_ctrl_pkg::ALU_SUB : core_ctrl_pkg::ALU_ADD;
      3'b001: alu_code = core_ctrl_pkg::ALU_SLL;
      3'b010: alu_code = core_ctrl_pkg::ALU_SLT;
      3'b011: alu_code = core_ctrl_pkg::ALU_SLTU;
      3'b100: alu_code = core_ctrl_pkg::ALU_XOR;
      3'b101: alu_code = (funct7 == rv_isa_pkg::F7_ALT) ?
                         core_ctrl_pkg::ALU_SRA : core_ctrl_pkg::ALU_SRL;
      3'b110: alu_code = core_ctrl_pkg::ALU_OR;
      default: alu_code = core_ctrl_pkg::ALU_AND;
    endcase
  end

  // legal encodings per opcode, everything else falls through as a no-op
  assign imm_ok = (funct3 == 3'b001) ? (funct7 == 7'd0) :
                  (funct3 == 3'b101) ? (funct7 == 7'd0 || funct7 == rv_isa_pkg::F7_ALT) :
                  1'b1;
  assign op_ok = (funct7 == 7'd0) ||
                 (funct7 == rv_isa_pkg::F7_ALT && (funct3 == 3'b000 || funct3 == 3'b101));
  assign load_ok = (funct3[1:0] != 2'b11) && !(funct3[2] && funct3[1]);
  assign is_ecall = (insn.i.imm == 12'd0) && (insn.i.rs1 == 5'd0) &&
                    (funct3 == 3'b000) && (insn.i.rd == 5'd0);

  always_comb begin
    reg_we = 1'b0;
    alu_op = core_ctrl_pkg::ALU_ADD;
    alu_src_imm = 1'b0;
    alu_src_pc = 1'b0;
    imm_sel = core_ctrl_pkg::IMM_I;
    wb_sel = core_ctrl_pkg::WB_ALU;
    pc_sel = core_ctrl_pkg::PC_SEQ;
    is_load = 1'b0;
    is_store = 1'b0;
    mem_size = funct3[1:0];
    load_unsigned = funct3[2];
    branch_funct = funct3;
    halt = 1'b0;
    case (opcode)
      rv_isa_pkg::OP_LUI: begin
        reg_we = 1'b1;
        imm_sel = core_ctrl_pkg::IMM_U;
        wb_sel = core_ctrl_pkg::WB_IMM;
      end
      rv_isa_pkg::OP_AUIPC: begin
        reg_we = 1'b1;
        imm_sel = core_ctrl_pkg::IMM_U;
        alu_src_pc = 1'b1;
        alu_src_imm = 1'b1;
      end
      rv_isa_pkg::OP_JAL: begin
        reg_we = 1'b1;
        imm_sel = core_ctrl_pkg::IMM_J;
        pc_sel = core_ctrl_pkg::PC_JAL;
        wb_sel = core_ctrl_pkg::WB_PC_PLUS4;
      end
      rv_isa_pkg::OP_JALR: begin
        if (funct3 == 3'b000) begin
          reg_we = 1'b1;
          pc_sel = core_ctrl_pkg::PC_JALR;
          wb_sel = core_ctrl_pkg::WB_PC_PLUS4;
        end
      end
      rv_isa_pkg::OP_BRANCH: begin
        // funct3 010 and 011 are reserved
        if (funct3[2:1] != 2'b01) begin
          imm_sel = core_ctrl_pkg::IMM_B;
          pc_sel = core_ctrl_pkg::PC_BRANCH;
        end
      end
      rv_isa_pkg::OP_LOAD: begin
        if (load_ok) begin
          reg_we = 1'b1;
          alu_src_imm = 1'b1;
          wb_sel = core_ctrl_pkg::WB_LOAD;
          is_load = 1'b1;
        end
      end
      rv_isa_pkg::OP_STORE: begin
        if (funct3 < 3'b011) begin
          imm_sel = core_ctrl_pkg::IMM_S;
          alu_src_imm = 1'b1;
          is_store = 1'b1;
        end
      end
      rv_isa_pkg::OP_OP_IMM: begin
        if (imm_ok) begin
          reg_we = 1'b1;
          alu_src_imm = 1'b1;
          alu_op = alu_code;
        end
      end
      rv_isa_pkg::OP_OP: begin
        if (op_ok) begin
          reg_we = 1'b1;
          alu_op = alu_code;
        end
      end
      rv_isa_pkg::OP_SYSTEM: begin
        halt = is_ecall;
      end
      // fence has no effect on a core with a single memory port
      rv_isa_pkg::OP_MISC_MEM: begin
      end
      default: begin
      end
    endcase
  end

endmodule

//--- logic/reg_file.sv
`timescale 1ns/1ps

module reg_file #(
  parameter int NUM_REGS = 32
) (
  input  logic                              clk,
  input  logic                              rst,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs1_addr,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rs2_addr,
  input  logic [rv_isa_pkg::REG_ADDR_W-1:0] rd_addr,
  input  logic [rv_isa_pkg::XLEN-1:0]       rd_data,
  input  logic                              we,
  output logic [rv_isa_pkg::XLEN-1:0]       rs1_data,
  output logic [rv_isa_pkg::XLEN-1:0]       rs2_data
);

  logic [rv_isa_pkg::XLEN-1:0] regs [NUM_REGS];

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      for (int i = 0; i < NUM_REGS; i++) begin
        regs[i] <= '0;
      end
    end else if (we && rd_addr != '0 && rd_addr < NUM_REGS) begin
      regs[rd_addr] <= rd_data;
    end
  end

  // x0 and indices past a reduced file read as zero
  assign rs1_data = (rs1_addr != '0 && rs1_addr < NUM_REGS) ? regs[rs1_addr] : '0;
  assign rs2_data = (rs2_addr != '0 && rs2_addr < NUM_REGS) ? regs[rs2_addr] : '0;

endmodule

//--- logic/imm_gen.sv
`timescale 1ns/1ps

module imm_gen (
  input  rv_isa_pkg::insn_t                   insn,
  input  logic [core_ctrl_pkg::IMM_SEL_W-1:0] imm_sel,
  output logic [rv_isa_pkg::XLEN-1:0]         imm
);

  always_comb begin
    case (imm_sel)
      core_ctrl_pkg::IMM_I: begin
        imm = {{20{insn.i.imm[11]}}, insn.i.imm};
      end
      core_ctrl_pkg::IMM_S: begin
        imm = {{20{insn.s.imm_hi[6]}}, insn.s.imm_hi, insn.s.imm_lo};
      end
      core_ctrl_pkg::IMM_B: begin
        imm = {{20{insn.b.imm_12}}, insn.b.imm_11, insn.b.imm_10_5, insn.b.imm_4_1, 1'b0};
      end
      core_ctrl_pkg::IMM_U: begin
        imm = {insn.u.imm, 12'h000};
      end
      core_ctrl_pkg::IMM_J: begin
        imm = {{12{insn.j.imm_20}}, insn.j.imm_19_12, insn.j.imm_11,
               insn.j.imm_10_1, 1'b0};
      end
      default: begin
        imm = '0;
      end
    endcase
  end

endmodule

//--- logic/alu.sv
`timescale 1ns/1ps

module alu (
  input  logic [rv_isa_pkg::XLEN-1:0]        a,
  input  logic [rv_isa_pkg::XLEN-1:0]        b,
  input  logic [core_ctrl_pkg::ALU_OP_W-1:0] alu_op,
  output logic [rv_isa_pkg::XLEN-1:0]        result
);

  logic [4:0] shamt;

  // only the low five bits shift, as both shift forms require
  assign shamt = b[4:0];

  always_comb begin
    case (alu_op)
      core_ctrl_pkg::ALU_ADD: result = a + b;
      core_ctrl_pkg::ALU_SUB: result = a - b;
      core_ctrl_pkg::ALU_SLL: result = a << shamt;
      core_ctrl_pkg::ALU_SLT: result = {31'd0, $signed(a) < $signed(b)};
      core_ctrl_pkg::ALU_SLTU: result = {31'd0, a < b};
      core_ctrl_pkg::ALU_XOR: result = a ^ b;
      core_ctrl_pkg::ALU_SRL: result = a >> shamt;
      core_ctrl_pkg::ALU_SRA: result = $unsigned($signed(a) >>> shamt);
      core_ctrl_pkg::ALU_OR: result = a | b;
      core_ctrl_pkg::ALU_AND: result = a & b;
      default: result = a + b;
    endcase
  end

endmodule

//--- logic/pc_unit.sv
`timescale 1ns/1ps

module pc_unit #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000
) (
  input  logic                               clk,
  input  logic                               rst,
  input  logic [core_ctrl_pkg::PC_SEL_W-1:0] pc_sel,
  input  logic [2:0]                         branch_funct,
  input  logic [rv_isa_pkg::XLEN-1:0]        rs1_data,
  input  logic [rv_isa_pkg::XLEN-1:0]        rs2_data,
  input  logic [rv_isa_pkg::XLEN-1:0]        imm,
  output logic [rv_isa_pkg::XLEN-1:0]        pc,
  output logic [rv_isa_pkg::XLEN-1:0]        pc_plus4
);

  logic taken;
  logic [rv_isa_pkg::XLEN-1:0] jalr_sum;
  logic [rv_isa_pkg::XLEN-1:0] pc_next;

  always_comb begin
    case (branch_funct)
      3'b000: taken = (rs1_data == rs2_data);
      3'b001: taken = (rs1_data != rs2_data);
      3'b100: taken = ($signed(rs1_data) < $signed(rs2_data));
      3'b101: taken = ($signed(rs1_data) >= $signed(rs2_data));
      3'b110: taken = (rs1_data < rs2_data);
      3'b111: taken = (rs1_data >= rs2_data);
      default: taken = 1'b0;
    endcase
  end

  assign pc_plus4 = pc + 32'd4;
  assign jalr_sum = rs1_data + imm;

  always_comb begin
    case (pc_sel)
      core_ctrl_pkg::PC_BRANCH: pc_next = taken ? pc + imm : pc_plus4;
      core_ctrl_pkg::PC_JAL: pc_next = pc + imm;
      // jalr target always drops bit zero
      core_ctrl_pkg::PC_JALR: pc_next = {jalr_sum[31:1], 1'b0};
      default: pc_next = pc_plus4;
    endcase
  end

  always_ff @(posedge clk or posedge rst) begin
    if (rst) begin
      pc <= RESET_PC;
    end else begin
      pc <= pc_next;
    end
  end

endmodule

//--- logic/load_store_unit.sv
`timescale 1ns/1ps

module load_store_unit (
  input  logic [1:0]                           addr_low,
  input  logic [core_ctrl_pkg::MEM_SIZE_W-1:0] mem_size,
  input  logic                                 load_unsigned,
  input  logic                                 is_store,
  input  logic                                 is_load,
  input  logic [rv_isa_pkg::XLEN-1:0]          rs2_data,
  input  logic [rv_isa_pkg::XLEN-1:0]          dmem_load_data,
  output logic [rv_isa_pkg::XLEN-1:0]          store_data,
  output logic [3:0]                           store_we,
  output logic [rv_isa_pkg::XLEN-1:0]          load_result
);

  logic [rv_isa_pkg::XLEN-1:0] lane_word;
  logic [rv_isa_pkg::XLEN-1:0] load_ext;
  logic [3:0] lane_mask;

  // value is copied into every lane, the enables pick the one that lands
  always_comb begin
    case (mem_size)
      core_ctrl_pkg::MEM_BYTE: begin
        store_data = {4{rs2_data[7:0]}};
        lane_mask = 4'b0001 << addr_low;
      end
      core_ctrl_pkg::MEM_HALF: begin
        store_data = {2{rs2_data[15:0]}};
        lane_mask = addr_low[1] ? 4'b1100 : 4'b0011;
      end
      default: begin
        store_data = rs2_data;
        lane_mask = 4'b1111;
      end
    endcase
  end

  assign store_we = is_store ? lane_mask : 4'b0000;

  // bring the addressed lane down to bit zero
  assign lane_word = dmem_load_data >> {addr_low, 3'b000};

  always_comb begin
    case (mem_size)
      core_ctrl_pkg::MEM_BYTE: begin
        load_ext = {{24{lane_word[7] & ~load_unsigned}}, lane_word[7:0]};
      end
      core_ctrl_pkg::MEM_HALF: begin
        load_ext = {{16{lane_word[15] & ~load_unsigned}}, lane_word[15:0]};
      end
      default: begin
        load_ext = dmem_load_data;
      end
    endcase
  end

  assign load_result = is_load ? load_ext : '0;

endmodule

//--- logic/riscv_core.sv
`timescale 1ns/1ps

module riscv_core #(
  parameter logic [31:0] RESET_PC = 32'h0000_0000,
  parameter int          NUM_REGS = 32
) (
  input  logic        clk,
  input  logic        rst,
  output logic [31:0] pc,
  input  logic [31:0] insn,
  output logic [31:0] dmem_addr,
  input  logic [31:0] dmem_load_data,
  output logic [31:0] dmem_store_data,
  output logic [3:0]  dmem_store_we,
  output logic        halt
);

  rv_isa_pkg::insn_t insn_word;

  logic reg_we;
  logic [core_ctrl_pkg::ALU_OP_W-1:0] alu_op;
  logic alu_src_imm;
  logic alu_src_pc;
  logic [core_ctrl_pkg::IMM_SEL_W-1:0] imm_sel;
  logic [core_ctrl_pkg::WB_SEL_W-1:0] wb_sel;
  logic [core_ctrl_pkg::PC_SEL_W-1:0] pc_sel;
  logic is_load;
  logic is_store;
  logic [core_ctrl_pkg::MEM_SIZE_W-1:0] mem_size;
  logic load_unsigned;
  logic [2:0] branch_funct;

  logic [31:0] rs1_data;
  logic [31:0] rs2_data;
  logic [31:0] imm;
  logic [31:0] alu_a;
  logic [31:0] alu_b;
  logic [31:0] alu_result;
  logic [31:0] pc_plus4;
  logic [31:0] load_result;
  logic [31:0] wb_data;

  assign insn_word = insn;

  core_decoder u_core_decoder (
    .insn          (insn_word),
    .reg_we        (reg_we),
    .alu_op        (alu_op),
    .alu_src_imm   (alu_src_imm),
    .alu_src_pc    (alu_src_pc),
    .imm_sel       (imm_sel),
    .wb_sel        (wb_sel),
    .pc_sel        (pc_sel),
    .is_load       (is_load),
    .is_store      (is_store),
    .mem_size      (mem_size),
    .load_unsigned (load_unsigned),
    .branch_funct  (branch_funct),
    .halt          (halt)
  );

  reg_file #(
    .NUM_REGS (NUM_REGS)
  ) u_reg_file (
    .clk      (clk),
    .rst      (rst),
    .rs1_addr (insn_word.r.rs1),
    .rs2_addr (insn_word.r.rs2),
    .rd_addr  (insn_word.r.rd),
    .rd_data  (wb_data),
    .we       (reg_we),
    .rs1_data (rs1_data),
    .rs2_data (rs2_data)
  );

  imm_gen u_imm_gen (
    .insn    (insn_word),
    .imm_sel (imm_sel),
    .imm     (imm)
  );

  // auipc adds to pc, everything else starts from rs1
  assign alu_a = alu_src_pc ? pc : rs1_data;
  assign alu_b = alu_src_imm ? imm : rs2_data;

  alu u_alu (
    .a      (alu_a),
    .b      (alu_b),
    .alu_op (alu_op),
    .result (alu_result)
  );

  pc_unit #(
    .RESET_PC (RESET_PC)
  ) u_pc_unit (
    .clk          (clk),
    .rst          (rst),
    .pc_sel       (pc_sel),
    .branch_funct (branch_funct),
    .rs1_data     (rs1_data),
    .rs2_data     (rs2_data),
    .imm          (imm),
    .pc           (pc),
    .pc_plus4     (pc_plus4)
  );

  load_store_unit u_load_store_unit (
    .addr_low       (alu_result[1:0]),
    .mem_size       (mem_size),
    .load_unsigned  (load_unsigned),
    .is_store       (is_store),
    .is_load        (is_load),
    .rs2_data       (rs2_data),
    .dmem_load_data (dmem_load_data),
    .store_data     (dmem_store_data),
    .store_we       (dmem_store_we),
    .load_result    (load_result)
  );

  // the effective address leaves the core unaligned, memory ignores the low bits
  assign dmem_addr = alu_result;

  always_comb begin
    case (wb_sel)
      core_ctrl_pkg::WB_LOAD: wb_data = load_result;
      core_ctrl_pkg::WB_PC_PLUS4: wb_data = pc_plus4;
      core_ctrl_pkg::WB_IMM: wb_data = imm;
      default: wb_data = alu_result;
    endcase
  end

endmodule

//--- include/core_test_table.svh
`ifndef CORE_TEST_TABLE_SVH
`define CORE_TEST_TABLE_SVH

// each row holds insn, load data, expected pc, memory check flag, dmem_addr,
// store data with disabled lanes ignored, store enables and halt
task load_program();
  // no-op straight after reset
  add_row(32'h0000_0013, 32'h0, 32'h0000_0000, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  // x1 = 0x12345678 from lui and addi
  add_row(32'h1234_50b7, 32'h0, 32'h0000_0004, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h6780_8093, 32'h0, 32'h0000_0008, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0010_2023, 32'h0, 32'h0000_000c, 1'b1, 32'h00, 32'h1234_5678, 4'hf, 1'b0);
  // x2 = -5
  add_row(32'hffb0_0113, 32'h0, 32'h0000_0010, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  // each of add, sub, xor, or and and is followed by sw
  add_row(32'h0020_81b3, 32'h0, 32'h0000_0014, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0030_2223, 32'h0, 32'h0000_0018, 1'b1, 32'h04, 32'h1234_5673, 4'hf, 1'b0);
  add_row(32'h4020_8233, 32'h0, 32'h0000_001c, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0040_2423, 32'h0, 32'h0000_0020, 1'b1, 32'h08, 32'h1234_567d, 4'hf, 1'b0);
  add_row(32'h0020_c2b3, 32'h0, 32'h0000_0024, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0050_2623, 32'h0, 32'h0000_0028, 1'b1, 32'h0c, 32'hedcb_a983, 4'hf, 1'b0);
  add_row(32'h0030_e333, 32'h0, 32'h0000_002c, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0060_2823, 32'h0, 32'h0000_0030, 1'b1, 32'h10, 32'h1234_567b, 4'hf, 1'b0);
  add_row(32'h0041_f3b3, 32'h0, 32'h0000_0034, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0070_2a23, 32'h0, 32'h0000_0038, 1'b1, 32'h14, 32'h1234_5671, 4'hf, 1'b0);
  // slt -5 < x1 and sltu x1 < 0xfffffffb both give 1
  add_row(32'h0011_2433, 32'h0, 32'h0000_003c, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0080_2c23, 32'h0, 32'h0000_0040, 1'b1, 32'h18, 32'h0000_0001, 4'hf, 1'b0);
  add_row(32'h0020_b4b3, 32'h0, 32'h0000_0044, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0090_2e23, 32'h0, 32'h0000_0048, 1'b1, 32'h1c, 32'h0000_0001, 4'hf, 1'b0);
  // slli, srli, srai by 4
  add_row(32'h0040_9513, 32'h0, 32'h0000_004c, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h02a0_2023, 32'h0, 32'h0000_0050, 1'b1, 32'h20, 32'h2345_6780, 4'hf, 1'b0);
  add_row(32'h0041_5593, 32'h0, 32'h0000_0054, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h02b0_2223, 32'h0, 32'h0000_0058, 1'b1, 32'h24, 32'h0fff_ffff, 4'hf, 1'b0);
  add_row(32'h4041_5613, 32'h0, 32'h0000_005c, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h02c0_2423, 32'h0, 32'h0000_0060, 1'b1, 32'h28, 32'hffff_ffff, 4'hf, 1'b0);
  // auipc at 0x64 adds 0x1000
  add_row(32'h0000_1697, 32'h0, 32'h0000_0064, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h02d0_2623, 32'h0, 32'h0000_0068, 1'b1, 32'h2c, 32'h0000_1064, 4'hf, 1'b0);
  // addi into x0 must not stick
  add_row(32'h0010_8013, 32'h0, 32'h0000_006c, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0200_2823, 32'h0, 32'h0000_0070, 1'b1, 32'h30, 32'h0000_0000, 4'hf, 1'b0);
  // sb at each lane and then sh low and high
  add_row(32'h0410_0023, 32'h0, 32'h0000_0074, 1'b1, 32'h40, 32'h7878_7878, 4'h1, 1'b0);
  add_row(32'h0410_00a3, 32'h0, 32'h0000_0078, 1'b1, 32'h41, 32'h7878_7878, 4'h2, 1'b0);
  add_row(32'h0410_0123, 32'h0, 32'h0000_007c, 1'b1, 32'h42, 32'h7878_7878, 4'h4, 1'b0);
  add_row(32'h0410_01a3, 32'h0, 32'h0000_0080, 1'b1, 32'h43, 32'h7878_7878, 4'h8, 1'b0);
  add_row(32'h0410_1223, 32'h0, 32'h0000_0084, 1'b1, 32'h44, 32'h5678_5678, 4'h3, 1'b0);
  add_row(32'h0410_1323, 32'h0, 32'h0000_0088, 1'b1, 32'h46, 32'h5678_5678, 4'hc, 1'b0);
  // lb, lbu, lh, lhu and lw from word 0xa1b2c3d4 with each result stored back
  add_row(32'h0510_0703, 32'ha1b2_c3d4, 32'h0000_008c, 1'b1, 32'h51, 32'h0, 4'h0, 1'b0);
  add_row(32'h06e0_2023, 32'h0, 32'h0000_0090, 1'b1, 32'h60, 32'hffff_ffc3, 4'hf, 1'b0);
  add_row(32'h0520_4783, 32'ha1b2_c3d4, 32'h0000_0094, 1'b1, 32'h52, 32'h0, 4'h0, 1'b0);
  add_row(32'h06f0_2223, 32'h0, 32'h0000_0098, 1'b1, 32'h64, 32'h0000_00b2, 4'hf, 1'b0);
  add_row(32'h0500_1803, 32'ha1b2_c3d4, 32'h0000_009c, 1'b1, 32'h50, 32'h0, 4'h0, 1'b0);
  add_row(32'h0700_2423, 32'h0, 32'h0000_00a0, 1'b1, 32'h68, 32'hffff_c3d4, 4'hf, 1'b0);
  add_row(32'h0520_5883, 32'ha1b2_c3d4, 32'h0000_00a4, 1'b1, 32'h52, 32'h0, 4'h0, 1'b0);
  add_row(32'h0710_2623, 32'h0, 32'h0000_00a8, 1'b1, 32'h6c, 32'h0000_a1b2, 4'hf, 1'b0);
  add_row(32'h0540_2903, 32'ha1b2_c3d4, 32'h0000_00ac, 1'b1, 32'h54, 32'h0, 4'h0, 1'b0);
  add_row(32'h0720_2823, 32'h0, 32'h0000_00b0, 1'b1, 32'h70, 32'ha1b2_c3d4, 4'hf, 1'b0);
  // each branch type not taken and then taken
  add_row(32'h0020_8463, 32'h0, 32'h0000_00b4, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0010_8463, 32'h0, 32'h0000_00b8, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0010_9463, 32'h0, 32'h0000_00c0, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0020_9663, 32'h0, 32'h0000_00c4, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0020_c463, 32'h0, 32'h0000_00d0, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0011_4863, 32'h0, 32'h0000_00d4, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0011_5463, 32'h0, 32'h0000_00e4, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0020_d463, 32'h0, 32'h0000_00e8, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0011_6463, 32'h0, 32'h0000_00f0, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0020_e463, 32'h0, 32'h0000_00f4, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0020_f463, 32'h0, 32'h0000_00fc, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0011_7463, 32'h0, 32'h0000_0100, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  // jal x19 +16 and then jalr x20 to x19 + 0xf5 with bit zero dropped
  add_row(32'h0100_09ef, 32'h0, 32'h0000_0108, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0730_2a23, 32'h0, 32'h0000_0118, 1'b1, 32'h74, 32'h0000_010c, 4'hf, 1'b0);
  add_row(32'h0f59_8a67, 32'h0, 32'h0000_011c, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0740_2c23, 32'h0, 32'h0000_0200, 1'b1, 32'h78, 32'h0000_0120, 4'hf, 1'b0);
  // register sll, srl and sra take the amount 27 from the low five bits of x2
  add_row(32'h0020_9ab3, 32'h0, 32'h0000_0204, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0750_2e23, 32'h0, 32'h0000_0208, 1'b1, 32'h7c, 32'hc000_0000, 4'hf, 1'b0);
  add_row(32'h0021_5b33, 32'h0, 32'h0000_020c, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0960_2023, 32'h0, 32'h0000_0210, 1'b1, 32'h80, 32'h0000_001f, 4'hf, 1'b0);
  add_row(32'h4021_5bb3, 32'h0, 32'h0000_0214, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0970_2223, 32'h0, 32'h0000_0218, 1'b1, 32'h84, 32'hffff_ffff, 4'hf, 1'b0);
  // mul from the dropped M extension is a no-op and leaves x24 at zero
  add_row(32'h0220_8c33, 32'h0, 32'h0000_021c, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0980_2423, 32'h0, 32'h0000_0220, 1'b1, 32'h88, 32'h0000_0000, 4'hf, 1'b0);
  // fence is a no-op and ecall halts for one cycle only
  add_row(32'h0ff0_000f, 32'h0, 32'h0000_0224, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
  add_row(32'h0000_0073, 32'h0, 32'h0000_0228, 1'b0, 32'h0, 32'h0, 4'h0, 1'b1);
  add_row(32'h0000_0013, 32'h0, 32'h0000_022c, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
endtask

`endif

//--- dv/riscv_core_tb.sv
`timescale 1ns/1ps

module riscv_core_tb;

  localparam int CLK_PERIOD = 20;
  localparam int RESET_CYCLES = 10;
  localparam int MARGIN_CYCLES = 20;
  localparam logic [31:0] RESET_PC = 32'h0000_0000;
  localparam logic [31:0] NOP_INSN = 32'h0000_0013;

  logic clk;
  logic rst;
  logic [31:0] insn;
  logic [31:0] dmem_load_data;
  logic [31:0] pc;
  logic [31:0] dmem_addr;
  logic [31:0] dmem_store_data;
  logic [3:0] dmem_store_we;
  logic halt;

  // one entry per table row
  logic [31:0] row_insn [$];
  logic [31:0] row_load [$];
  logic [31:0] row_pc [$];
  logic row_mem [$];
  logic [31:0] row_addr [$];
  logic [31:0] row_sdata [$];
  logic [3:0] row_we [$];
  logic row_halt [$];

  bit table_ready;
  int errors;
  int checks;

  riscv_core u_riscv_core (
    .clk             (clk),
    .rst             (rst),
    .pc              (pc),
    .insn            (insn),
    .dmem_addr       (dmem_addr),
    .dmem_load_data  (dmem_load_data),
    .dmem_store_data (dmem_store_data),
    .dmem_store_we   (dmem_store_we),
    .halt            (halt)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic add_row(
    input logic [31:0] insn_word,
    input logic [31:0] load_word,
    input logic [31:0] exp_pc,
    input logic        mem_check,
    input logic [31:0] exp_addr,
    input logic [31:0] exp_sdata,
    input logic [3:0]  exp_we,
    input logic        exp_halt
  );
    row_insn.push_back(insn_word);
    row_load.push_back(load_word);
    row_pc.push_back(exp_pc);
    row_mem.push_back(mem_check);
    row_addr.push_back(exp_addr);
    row_sdata.push_back(exp_sdata);
    row_we.push_back(exp_we);
    row_halt.push_back(exp_halt);
  endtask

  `include "core_test_table.svh"

  // byte enables widened to a bit mask over the data word
  function automatic logic [31:0] lane_mask(input logic [3:0] we);
    return {{8{we[3]}}, {8{we[2]}}, {8{we[1]}}, {8{we[0]}}};
  endfunction

  task automatic check_outputs(
    input int          row,
    input logic [31:0] exp_pc,
    input logic        mem_check,
    input logic [31:0] exp_addr,
    input logic [31:0] exp_sdata,
    input logic [3:0]  exp_we,
    input logic        exp_halt
  );
    logic [31:0] mask;
    mask = lane_mask(exp_we);
    checks += 3;
    assert (pc === exp_pc) else begin
      errors++;
      $display("Error: pc expected %h got %h at row %0d", exp_pc, pc, row);
    end
    assert (dmem_store_we === exp_we) else begin
      errors++;
      $display("Error: dmem_store_we expected %h got %h at row %0d",
               exp_we, dmem_store_we, row);
    end
    assert (halt === exp_halt) else begin
      errors++;
      $display("Error: halt expected %h got %h at row %0d", exp_halt, halt, row);
    end
    if (mem_check) begin
      checks += 2;
      assert (dmem_addr === exp_addr) else begin
        errors++;
        $display("Error: dmem_addr expected %h got %h at row %0d",
                 exp_addr, dmem_addr, row);
      end
      assert ((dmem_store_data & mask) === (exp_sdata & mask)) else begin
        errors++;
        $display("Error: dmem_store_data expected %h got %h at row %0d",
                 exp_sdata & mask, dmem_store_data & mask, row);
      end
    end
  endtask

  // limit follows the table length
  initial begin
    int limit_cycles;
    wait (table_ready);
    limit_cycles = row_insn.size() + RESET_CYCLES + MARGIN_CYCLES;
    #(limit_cycles * CLK_PERIOD);
    $display("watchdog expired before the instruction table finished");
    $display("SIMULATION FAILED");
    $finish;
  end

  initial begin
    clk = 1'b0;
    rst = 1'b1;
    insn = NOP_INSN;
    dmem_load_data = 32'h0;
    errors = 0;
    checks = 0;
    load_program();
    table_ready = 1'b1;

    // pc and outputs stay quiet while reset is held
    repeat (RESET_CYCLES) begin
      @(posedge clk);
      #(CLK_PERIOD / 4);
      check_outputs(-1, RESET_PC, 1'b0, 32'h0, 32'h0, 4'h0, 1'b0);
    end
    @(negedge clk);
    rst = 1'b0;

    for (int i = 0; i < row_insn.size(); i++) begin
      if (i > 0) begin
        @(negedge clk);
      end
      insn = row_insn[i];
      dmem_load_data = row_load[i];
      #(CLK_PERIOD / 4);
      check_outputs(i, row_pc[i], row_mem[i], row_addr[i], row_sdata[i],
                    row_we[i], row_halt[i]);
    end

    $display("checks run: %0d, errors: %0d", checks, errors);
    if (errors == 0) begin
      $display("SIMULATION PASSED");
    end else begin
      $display("SIMULATION FAILED");
    end
    $finish;
  end

endmodule

//--- vlog.f
+incdir+include
logic/rv_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/core_decoder.sv
logic/reg_file.sv
logic/imm_gen.sv
logic/alu.sv
logic/pc_unit.sv
logic/load_store_unit.sv
logic/riscv_core.sv
dv/riscv_core_tb.sv
